//--- tb.f
rtl/fade_pkg.sv
rtl/timebase_pkg.sv
rtl/timebase.sv
rtl/color_wheel.sv
rtl/pwm_bank.sv
rtl/led_drive.sv
rtl/rgb_fader.sv
test/tb_clock.sv
test/tb_rgb_fader.sv

//--- Bender.yml
package:
  name: rgb_fader

sources:
  - rtl/fade_pkg.sv
  - rtl/timebase_pkg.sv
  - rtl/timebase.sv
  - rtl/color_wheel.sv
  - rtl/pwm_bank.sv
  - rtl/led_drive.sv
  - rtl/rgb_fader.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/tb_rgb_fader.sv

//--- test/tb_rgb_fader.sv
// ----------------------------------------------------------
// Testbench for the RGB fader at prescale 0
// Own cycle model of the colour wheel and PWM, checked by
// concurrent assertions over one full wheel plus the wrap
// ----------------------------------------------------------

module tb_rgb_fader;

  localparam int unsigned WHEEL_CYCLES   = 32'd1 << 20;          // One hue cycle
  localparam int unsigned RUN_CYCLES     = WHEEL_CYCLES + 512;
  localparam int unsigned TIMEOUT_CYCLES = WHEEL_CYCLES + 4096;
  localparam int unsigned PULSE_STOP     = WHEEL_CYCLES - 1024;  // Enable steady over the wrap
  localparam logic [2:0]  PINS_OFF       = 3'b111;

  logic        clk;
  logic        arst_n;
  logic        led_en;
  logic        rgb0;
  logic        rgb1;
  logic        rgb2;
  logic [2:0]  pins;        // {blue, red, green}
  int          seed;
  int          fail_count = 0;
  int          pulses = 0;
  int unsigned wd_cycles = 0;

  // Model state that tracks the DUT counter value
  logic [31:0] cyc;
  logic        en_q;        // led_en as sampled by the drive stage
  logic        en_qq;
  logic [2:0]  hist0;       // Lit flags {b, r, g} newest first
  logic [2:0]  hist1;
  logic [2:0]  hist2;
  logic [2:0]  exp_pins;
  logic [31:0] pipe_n;      // Counter value seen on the pins now
  logic        pipe_ok;
  logic [1:0]  pipe_phase;
  logic [7:0]  pipe_pwm;

  // PWM period tally
  logic        win_en_ok;
  logic [31:0] win_base;
  logic [8:0]  low_r;
  logic [8:0]  low_g;
  logic [8:0]  low_b;
  logic        win_check;   // One cycle pulse per finished period
  logic [8:0]  done_r;
  logic [8:0]  done_g;
  logic [8:0]  done_b;
  logic [23:0] done_duty;   // {r, g, b}
  logic [31:0] done_base;
  logic        wrap_checked;

  tb_clock u_clock (
    .clk    (clk),
    .arst_n (arst_n)
  );

  rgb_fader #(
    .prescale_bits(0)
  ) uut (
    .clk    (clk),
    .arst_n (arst_n),
    .led_en (led_en),
    .rgb0   (rgb0),
    .rgb1   (rgb1),
    .rgb2   (rgb2)
  );

  // Colour table {r, g, b} for a counter value
  function automatic logic [23:0] hue_levels(input logic [31:0] n);
    logic [7:0] up;
    logic [7:0] dn;
    up = n[17:10];
    dn = 8'd255 - up;
    case (n[19:18])
      2'd0:    return {up, 8'd0, dn};
      2'd1:    return {8'd255, up, 8'd0};
      2'd2:    return {dn, 8'd255, 8'd0};
      default: return {8'd0, dn, up};
    endcase
  endfunction

  // Lit flags in pin order {b, r, g}
  function automatic logic [2:0] slot_lit(input logic [31:0] n);
    logic [23:0] lv;
    lv = hue_levels(n);
    return {n[7:0] < lv[7:0], n[7:0] < lv[23:16], n[7:0] < lv[15:8]};
  endfunction

  task automatic end_in_failure();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input int expected, input int actual);
    fail_count++;
    $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
    end_in_failure();
  endtask

  assign pins       = {rgb2, rgb1, rgb0};
  assign exp_pins   = ~(hist2 & {3{en_q}});  // Dark when disabled
  assign pipe_ok    = (cyc >= 3);
  assign pipe_n     = cyc - 3;
  assign pipe_phase = pipe_n[19:18];
  assign pipe_pwm   = pipe_n[7:0];

  // Reference pipeline three deep like the DUT
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cyc   <= '0;
      en_q  <= 1'b1;
      en_qq <= 1'b1;
      hist0 <= '0;  // Zero fill keeps pins dark
      hist1 <= '0;
      hist2 <= '0;
    end else begin
      cyc   <= cyc + 1;
      en_q  <= led_en;
      en_qq <= en_q;
      hist0 <= slot_lit(cyc);
      hist1 <= hist0;
      hist2 <= hist1;
    end
  end

  // Low-cycle count per pin over each aligned PWM period
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      win_en_ok    <= 1'b0;
      win_base     <= '0;
      low_r        <= '0;
      low_g        <= '0;
      low_b        <= '0;
      win_check    <= 1'b0;
      done_r       <= '0;
      done_g       <= '0;
      done_b       <= '0;
      done_duty    <= '0;
      done_base    <= '0;
      wrap_checked <= 1'b0;
    end else begin
      win_check <= 1'b0;
      if (win_check && done_base == WHEEL_CYCLES)
        wrap_checked <= 1'b1;
      if (pipe_ok) begin
        if (pipe_pwm == 8'd0) begin  // Period starts
          win_en_ok <= en_q;
          win_base  <= pipe_n;
          low_r     <= {8'd0, ~rgb1};
          low_g     <= {8'd0, ~rgb0};
          low_b     <= {8'd0, ~rgb2};
        end else begin
          win_en_ok <= win_en_ok & en_q;
          low_r     <= low_r + {8'd0, ~rgb1};
          low_g     <= low_g + {8'd0, ~rgb0};
          low_b     <= low_b + {8'd0, ~rgb2};
        end
        if (pipe_pwm == 8'd255) begin
          win_check <= win_en_ok & en_q;  // Only periods fully enabled
          done_r    <= low_r + {8'd0, ~rgb1};
          done_g    <= low_g + {8'd0, ~rgb0};
          done_b    <= low_b + {8'd0, ~rgb2};
          done_duty <= hue_levels(pipe_n);
          done_base <= win_base;
        end
      end
    end
  end

  reset_dark: assert property (@(posedge clk) (!arst_n || cyc < 3) |-> pins == PINS_OFF)
    else report_mismatch("reset", PINS_OFF, $sampled(pins));
  pin_levels: assert property (@(posedge clk) disable iff (!arst_n) pins == exp_pins)
    else report_mismatch("pin_levels", $sampled(exp_pins), $sampled(pins));

  lit_red: assert property (@(posedge clk) disable iff (!arst_n)
    win_check |-> done_r == {1'b0, done_duty[23:16]})
    else report_mismatch("lit_red", $sampled(done_duty[23:16]), $sampled(done_r));
  lit_green: assert property (@(posedge clk) disable iff (!arst_n)
    win_check |-> done_g == {1'b0, done_duty[15:8]})
    else report_mismatch("lit_green", $sampled(done_duty[15:8]), $sampled(done_g));
  lit_blue: assert property (@(posedge clk) disable iff (!arst_n)
    win_check |-> done_b == {1'b0, done_duty[7:0]})
    else report_mismatch("lit_blue", $sampled(done_duty[7:0]), $sampled(done_b));

  enable_off: assert property (@(posedge clk) disable iff (!arst_n) !en_q |-> pins == PINS_OFF)
    else report_mismatch("enable_off", PINS_OFF, $sampled(pins));
  enable_back: assert property (@(posedge clk) disable iff (!arst_n)
    (en_q && !en_qq) |-> pins == exp_pins)
    else report_mismatch("enable_back", $sampled(exp_pins), $sampled(pins));

  // Duty 255 lights every slot but the last
  full_red: assert property (@(posedge clk) disable iff (!arst_n)
    (pipe_ok && en_q && pipe_phase == 2'd1 && pipe_pwm != 8'hFF) |-> !rgb1)
    else report_mismatch("full_red", 0, $sampled(rgb1));
  full_green: assert property (@(posedge clk) disable iff (!arst_n)
    (pipe_ok && en_q && pipe_phase == 2'd2 && pipe_pwm != 8'hFF) |-> !rgb0)
    else report_mismatch("full_green", 0, $sampled(rgb0));
  full_last_slot: assert property (@(posedge clk) disable iff (!arst_n)
    (pipe_ok && en_q && pipe_phase == 2'd1 && pipe_pwm == 8'hFF) |-> rgb1)
    else report_mismatch("full_last_slot", 1, $sampled(rgb1));

  // First period after the wrap has red off and blue full
  wrap_restart: assert property (@(posedge clk) disable iff (!arst_n)
    (win_check && done_base == WHEEL_CYCLES) |-> {done_r, done_b} == {9'd0, 9'd255})
    else report_mismatch("wrap_restart", {9'd0, 9'd255}, $sampled({done_r, done_b}));

  always @(posedge clk) begin
    wd_cycles <= wd_cycles + 1;
    if (wd_cycles == TIMEOUT_CYCLES) begin
      $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      end_in_failure();
    end
  end

  // Random enable dropouts and then a steady run across the wrap
  initial begin
    int unsigned gap;
    int unsigned width;
    seed   = 54172;
    led_en = 1'b1;
    wait (arst_n === 1'b0);
    wait (arst_n === 1'b1);
    forever begin
      gap   = 1000 + ($unsigned($random(seed)) % 3000);
      width = 1 + ($unsigned($random(seed)) % 20);
      if (cyc + gap + 32 >= PULSE_STOP)
        break;
      repeat (gap) @(posedge clk);
      #1 led_en = 1'b0;
      repeat (width) @(posedge clk);
      #1 led_en = 1'b1;
      pulses++;
    end
    while (cyc < RUN_CYCLES)
      @(posedge clk);
    repeat (4) @(posedge clk);  // Let the last checks fire
    if (!wrap_checked) begin
      $display("ERROR: the PWM period after the wheel wrap was never checked");
      fail_count++;
    end
    if (pulses == 0) begin
      $display("ERROR: no enable dropout was driven");
      fail_count++;
    end
    if (fail_count == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      end_in_failure();
    end
  end

endmodule

//--- test/tb_clock.sv
// ----------------------------------------------------------
// Testbench clock and reset source for the fader
// 10 unit clock, async reset held low for two rising edges
// ----------------------------------------------------------

module tb_clock #(
  parameter int half_period  = 5,
  parameter int reset_cycles = 2
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  initial begin
    arst_n = 1'b1;
    #1 arst_n = 1'b0;                      // Falling edge fires the async reset
    repeat (reset_cycles) @(posedge clk);
    #1 arst_n = 1'b1;                      // Released just after an edge
  end

endmodule

//--- rtl/rgb_fader.sv
// ----------------------------------------------------------
// Top level of the tri-colour LED fader
// Timebase feeds decode, PWM and drive stages in a line
// A pin reflects the counter value of three cycles before
// ----------------------------------------------------------

module rgb_fader #(
  parameter int prescale_bits = timebase_pkg::PRESCALE_BITS_DEFAULT
) (
  input  logic clk,
  input  logic arst_n,
  input  logic led_en,  // Low blanks all three LEDs
  output logic rgb0,    // Green, active low
  output logic rgb1,    // Red, active low
  output logic rgb2     // Blue, active low
);

  import fade_pkg::*;
  import timebase_pkg::*;

  // Timebase fields
  phase_t   phase;
  ramp_t    ramp;
  pwm_cnt_t pwm_cnt;

  // Decoded duties
  duty_t duty_r;
  duty_t duty_g;
  duty_t duty_b;

  // PWM outputs
  logic on_r;
  logic on_g;
  logic on_b;

  timebase #(
    .prescale_bits(prescale_bits)
  ) u_timebase (
    .clk     (clk),
    .arst_n  (arst_n),
    .phase   (phase),
    .ramp    (ramp),
    .pwm_cnt (pwm_cnt)
  );

  color_wheel u_color_wheel (
    .clk    (clk),
    .arst_n (arst_n),
    .phase  (phase),
    .ramp   (ramp),
    .duty_r (duty_r),
    .duty_g (duty_g),
    .duty_b (duty_b)
  );

  pwm_bank u_pwm_bank (
    .clk     (clk),
    .arst_n  (arst_n),
    .pwm_cnt (pwm_cnt),  // Realigned inside
    .duty_r  (duty_r),
    .duty_g  (duty_g),
    .duty_b  (duty_b),
    .on_r    (on_r),
    .on_g    (on_g),
    .on_b    (on_b)
  );

  led_drive u_led_drive (
    .clk    (clk),
    .arst_n (arst_n),
    .led_en (led_en),
    .on_r   (on_r),
    .on_g   (on_g),
    .on_b   (on_b),
    .rgb0   (rgb0),
    .rgb1   (rgb1),
    .rgb2   (rgb2)
  );

endmodule

//--- rtl/led_drive.sv
// ----------------------------------------------------------
// Result stage of the fader
// Gates channels with the enable and drives active-low pins
// Pin 0 is green, pin 1 red, pin 2 blue
// ----------------------------------------------------------

module led_drive (
  input  logic clk,
  input  logic arst_n,
  input  logic led_en,  // Seen one cycle after sampling
  input  logic on_r,
  input  logic on_g,
  input  logic on_b,
  output logic rgb0,    // Green sink
  output logic rgb1,    // Red sink
  output logic rgb2     // Blue sink
);

  logic lit_r;
  logic lit_g;
  logic lit_b;

  // Enable gating
  assign lit_r = led_en & on_r;
  assign lit_g = led_en & on_g;
  assign lit_b = led_en & on_b;

  // Pull the pin low to light its LED
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rgb0 <= 1'b1;  // All dark in reset
      rgb1 <= 1'b1;
      rgb2 <= 1'b1;
    end else begin
      rgb0 <= ~lit_g;
      rgb1 <= ~lit_r;
      rgb2 <= ~lit_b;
    end
  end

endmodule

//--- rtl/pwm_bank.sv
// ----------------------------------------------------------
// Execute stage of the fader
// Three duty against count comparators on one shared count
// ----------------------------------------------------------

module pwm_bank (
  input  logic                   clk,
  input  logic                   arst_n,
  input  timebase_pkg::pwm_cnt_t pwm_cnt,  // Straight from the timebase
  input  fade_pkg::duty_t        duty_r,   // Already one cycle late
  input  fade_pkg::duty_t        duty_g,
  input  fade_pkg::duty_t        duty_b,
  output logic                   on_r,     // Two cycles behind the counter
  output logic                   on_g,
  output logic                   on_b
);

  import timebase_pkg::*;

  pwm_cnt_t cnt_q;  // Count aligned with the duty registers

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= pwm_cnt;
    end
  end

  // Lit while the slot is below the duty
  // Duty 0 never lights, 255 misses one slot
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      on_r <= 1'b0;
      on_g <= 1'b0;
      on_b <= 1'b0;
    end else begin
      on_r <= (cnt_q < duty_r);
      on_g <= (cnt_q < duty_g);
      on_b <= (cnt_q < duty_b);
    end
  end

endmodule

//--- rtl/color_wheel.sv
// ----------------------------------------------------------
// Decode stage of the fader
// Turns colour phase and ramp into registered RGB duties
// Hue walks red, yellow, green, cyan, blue, magenta
// ----------------------------------------------------------

module color_wheel (
  input  logic             clk,
  input  logic             arst_n,
  input  fade_pkg::phase_t phase,
  input  fade_pkg::ramp_t  ramp,
  output fade_pkg::duty_t  duty_r,  // One cycle behind the counter
  output fade_pkg::duty_t  duty_g,
  output fade_pkg::duty_t  duty_b
);

  import fade_pkg::*;

  duty_t ramp_up;    // Fading in
  duty_t ramp_down;  // Fading out
  duty_t nxt_r;
  duty_t nxt_g;
  duty_t nxt_b;

  assign ramp_up   = ramp;
  assign ramp_down = ~ramp;

  // Four-phase colour table
  always_comb begin
    nxt_r = '0;
    nxt_g = '0;
    nxt_b = '0;
    case (phase)
      PH_RED_UP: begin   // Magenta to red
        nxt_r = ramp_up;
        nxt_b = ramp_down;
      end
      PH_GRN_UP: begin   // Red to yellow
        nxt_r = DUTY_FULL;
        nxt_g = ramp_up;
      end
      PH_RED_DOWN: begin // Yellow to green
        nxt_r = ramp_down;
        nxt_g = DUTY_FULL;
      end
      default: begin     // Green through cyan to blue
        nxt_g = ramp_down;
        nxt_b = ramp_up;
      end
    endcase
  end

  // Duty registers, dark out of reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      duty_r <= '0;
      duty_g <= '0;
      duty_b <= '0;
    end else begin
      duty_r <= nxt_r;
      duty_g <= nxt_g;
      duty_b <= nxt_b;
    end
  end

endmodule

//--- rtl/timebase.sv
// ----------------------------------------------------------
// Free-running timebase for the fader pipeline
// One wide counter sliced into phase, ramp and PWM fields
// ----------------------------------------------------------

module timebase #(
  parameter int prescale_bits = timebase_pkg::PRESCALE_BITS_DEFAULT
) (
  input  logic                   clk,
  input  logic                   arst_n,
  output fade_pkg::phase_t       phase,   // Colour phase
  output fade_pkg::ramp_t        ramp,    // Brightness ramp
  output timebase_pkg::pwm_cnt_t pwm_cnt  // PWM slot count
);

  import timebase_pkg::*;

  // Field offsets, LSB first
  localparam int PWM_LSB   = prescale_bits;
  localparam int RAMP_LSB  = PWM_LSB + PWM_BITS + GAP_BITS;  // Gap bits skipped
  localparam int PHASE_LSB = RAMP_LSB + RAMP_BITS;
  localparam int CNT_BITS  = PHASE_LSB + PHASE_BITS;

  logic [CNT_BITS-1:0] cnt;  // Value n in cycle n after release

  // Wraps at full width, so the wheel repeats
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // Field slices straight off the register
  assign pwm_cnt = cnt[PWM_LSB +: PWM_BITS];
  assign ramp    = cnt[RAMP_LSB +: RAMP_BITS];
  assign phase   = cnt[PHASE_LSB +: PHASE_BITS];

endmodule

//--- rtl/timebase_pkg.sv
// ----------------------------------------------------------
// Field widths of the free-running timebase counter
// Prescale default suits the 48 MHz board clock
// ----------------------------------------------------------

package timebase_pkg;

  // Counter fields from the MSB down: phase, ramp, gap, pwm, prescale
  localparam int PHASE_BITS = 2;  // Four hue segments
  localparam int RAMP_BITS  = 8;  // Brightness steps per segment
  localparam int GAP_BITS   = 2;  // 4 PWM periods per ramp step
  localparam int PWM_BITS   = 8;  // 256 slots per PWM period

  // Low bits below the PWM field
  // 48 MHz / 2^9 gives about 94 kHz per PWM slot
  localparam int PRESCALE_BITS_DEFAULT = 9;

  // Shared PWM slot count
  typedef logic [PWM_BITS-1:0] pwm_cnt_t;

endpackage

//--- rtl/fade_pkg.sv
// ----------------------------------------------------------
// Colour level types and colour phase encoding for the fader
// Shared by the wheel decoder, the PWM bank and the top level
// ----------------------------------------------------------

package fade_pkg;

  // Brightness level, 0 is dark, 255 is lit 255 of 256 slots
  typedef logic [7:0] duty_t;

  // Brightness ramp slice of the timebase
  typedef logic [7:0] ramp_t;

  // Colour phase, a counter field and not an FSM state
  typedef logic [1:0] phase_t;

  // Full-scale duty
  localparam duty_t DUTY_FULL = 8'hFF;

  // Phase encoding around the colour wheel
  localparam phase_t PH_RED_UP   = 2'd0;  // Red rises, blue falls
  localparam phase_t PH_GRN_UP   = 2'd1;  // Red full, green rises
  localparam phase_t PH_RED_DOWN = 2'd2;  // Green full, red falls
  localparam phase_t PH_BLU_UP   = 2'd3;  // Green falls, blue rises

endpackage
